// ==== apb_insn_port.sv ====
/*
  APB3 slave for the decode slice with no wait states.
  A write to INSN pushes the word into the instruction queue, a read of
  STATUS returns the queue levels and the decoded count, and a read of
  RESULT returns the head record and pops it. Full pushes, empty pops,
  wrong-direction accesses and unmapped addresses raise pslverr.
*/

`timescale 1ns/1ps

module apb_insn_port (
	input  logic clk,
	input  logic rst_n,
	input  logic [decode_pkg::APB_ADDR_W-1:0] paddr,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [decode_pkg::INSN_W-1:0] pwdata,
	output logic [decode_pkg::INSN_W-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic insn_push,
	output logic [decode_pkg::INSN_W-1:0] insn_data,
	input  logic insn_full,
	input  logic [decode_pkg::INSN_LVL_W-1:0] insn_level,
	output logic res_pop,
	input  logic [decode_pkg::RESULT_W-1:0] res_data,
	input  logic res_empty,
	input  logic [decode_pkg::RES_LVL_W-1:0] res_level,
	input  logic [decode_pkg::CNT_W-1:0] decoded_count
);

	logic setup_q;
	logic access;
	logic sel_insn;
	logic sel_status;
	logic sel_result;
	logic unmapped;
	logic bad_dir;
	logic wr_insn;
	logic rd_result;
	logic [decode_pkg::INSN_W-1:0] status_word;

	// ========================================================================
	// Transfer phase tracking
	// ========================================================================

	// Remember that the previous cycle was a setup cycle
	// A master that holds psel and penable past the access cycle then
	// cannot push or pop a second time
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			setup_q <= 1'b0;
		else
			setup_q <= psel & ~penable;
	end

	assign access = psel & penable & setup_q;

	// No wait states in this slave
	assign pready = 1'b1;

	// ========================================================================
	// Address decode and queue control
	// ========================================================================

	assign sel_insn = (paddr == decode_pkg::ADDR_INSN);
	assign sel_status = (paddr == decode_pkg::ADDR_STATUS);
	assign sel_result = (paddr == decode_pkg::ADDR_RESULT);
	assign unmapped = ~(sel_insn | sel_status | sel_result);

	// INSN is write only, STATUS and RESULT are read only
	assign bad_dir = (sel_insn & ~pwrite) | ((sel_status | sel_result) & pwrite);

	assign wr_insn = access & pwrite & sel_insn;
	assign rd_result = access & ~pwrite & sel_result;

	// The write data goes straight into the queue, a full queue drops it
	assign insn_push = wr_insn & ~insn_full;
	assign insn_data = pwdata;
	assign res_pop = rd_result & ~res_empty;

	// Error is only ever flagged in the access cycle
	assign pslverr = access & (unmapped | bad_dir | (wr_insn & insn_full) |
		(rd_result & res_empty));

	// ========================================================================
	// Read data
	// ========================================================================

	// Levels are zero extended into their four bit slots
	always_comb
	begin
		status_word = '0;
		status_word[decode_pkg::ST_IQ_LSB +: decode_pkg::ST_LVL_W] =
			decode_pkg::ST_LVL_W'(insn_level);
		status_word[decode_pkg::ST_RQ_LSB +: decode_pkg::ST_LVL_W] =
			decode_pkg::ST_LVL_W'(res_level);
		status_word[decode_pkg::ST_CNT_LSB +: decode_pkg::CNT_W] = decoded_count;
	end

	// Read data is combinational so it is valid in the access cycle
	// An empty result queue reads as zero
	always_comb
	begin
		prdata = '0;
		if (psel && !pwrite)
		begin
			if (sel_status)
				prdata = status_word;
			else if (sel_result && !res_empty)
				prdata = decode_pkg::INSN_W'(res_data);
		end
	end

endmodule

// ==== decode_pkg.sv ====
/*
  Shared constants for the instruction decode slice.
  Holds the opcode values, the instruction field positions, the register
  number layout, the decoded record layout, the APB register map and the
  queue depths. Every other file reaches these by decode_pkg::name.
*/

package decode_pkg;

	// ========================================================================
	// Instruction word layout
	// ========================================================================

	// Instructions are fixed at 32 bits in this slice
	localparam int INSN_W = 32;

	// The opcode sits in the low bits of the word
	localparam int OPC_LSB = 0;
	localparam int OPC_W = 7;

	// Second source register field, six bits starting at bit 19
	localparam int RS2_LSB = 19;
	localparam int RS2_W = 6;

	// When this bit is set operand B is an immediate and there is no Rs2
	localparam int IMMB_BIT = 25;

	// CSR sub-function select, zero selects the register form
	localparam int CSR_SEL_LSB = 29;
	localparam int CSR_SEL_W = 3;

	// Architectural register number, the top two bits pick the bank
	localparam int AREG_W = 8;
	localparam int BANK_W = AREG_W - RS2_W;
	localparam logic [BANK_W-1:0] BANK_INT = 2'b00;
	localparam logic [BANK_W-1:0] BANK_FLT = 2'b01;

	// ========================================================================
	// Opcodes
	// ========================================================================

	// Floating point operations at four precisions
	localparam logic [OPC_W-1:0] OP_FLTH = 7'h50;
	localparam logic [OPC_W-1:0] OP_FLTS = 7'h51;
	localparam logic [OPC_W-1:0] OP_FLTD = 7'h52;
	localparam logic [OPC_W-1:0] OP_FLTQ = 7'h53;
	localparam logic [OPC_W-1:0] OP_CSR = 7'h07;
	// Signed and unsigned conditional branches
	localparam logic [OPC_W-1:0] OP_BCC8 = 7'h28;
	localparam logic [OPC_W-1:0] OP_BCC16 = 7'h29;
	localparam logic [OPC_W-1:0] OP_BCC32 = 7'h2A;
	localparam logic [OPC_W-1:0] OP_BCC64 = 7'h2B;
	localparam logic [OPC_W-1:0] OP_BCCU8 = 7'h2C;
	localparam logic [OPC_W-1:0] OP_BCCU16 = 7'h2D;
	localparam logic [OPC_W-1:0] OP_BCCU32 = 7'h2E;
	localparam logic [OPC_W-1:0] OP_BCCU64 = 7'h2F;
	// ALU operations with an immediate second operand
	localparam logic [OPC_W-1:0] OP_ADDI = 7'h04;
	localparam logic [OPC_W-1:0] OP_SUBFI = 7'h05;
	localparam logic [OPC_W-1:0] OP_CMPI = 7'h06;
	localparam logic [OPC_W-1:0] OP_ANDI = 7'h08;
	localparam logic [OPC_W-1:0] OP_ORI = 7'h09;
	localparam logic [OPC_W-1:0] OP_XORI = 7'h0A;
	localparam logic [OPC_W-1:0] OP_MULI = 7'h0C;
	localparam logic [OPC_W-1:0] OP_SHIFT = 7'h10;
	// Loads, stores and atomics
	localparam logic [OPC_W-1:0] OP_LDB = 7'h48;
	localparam logic [OPC_W-1:0] OP_LDW = 7'h4A;
	localparam logic [OPC_W-1:0] OP_LOAD = 7'h4E;
	localparam logic [OPC_W-1:0] OP_STB = 7'h38;
	localparam logic [OPC_W-1:0] OP_STW = 7'h39;
	localparam logic [OPC_W-1:0] OP_STORE = 7'h3B;
	localparam logic [OPC_W-1:0] OP_AMO = 7'h3E;
	localparam logic [OPC_W-1:0] OP_CMPSWAP = 7'h3F;

	// ========================================================================
	// Decoded record, queues and APB map
	// ========================================================================

	// Record is rs2 in 7:0, has_rs2 in 8, rs2z in 9 and the opcode in 16:10
	localparam int RESULT_W = 17;
	localparam int REC_RS2_LSB = 0;
	localparam int REC_HAS_BIT = 8;
	localparam int REC_Z_BIT = 9;
	localparam int REC_OPC_LSB = 10;

	localparam int INSN_DEPTH = 4;
	localparam int RESULT_DEPTH = 4;
	localparam int INSN_LVL_W = $clog2(INSN_DEPTH + 1);
	localparam int RES_LVL_W = $clog2(RESULT_DEPTH + 1);

	localparam int APB_ADDR_W = 4;
	localparam logic [APB_ADDR_W-1:0] ADDR_INSN = 4'h0;
	localparam logic [APB_ADDR_W-1:0] ADDR_STATUS = 4'h4;
	localparam logic [APB_ADDR_W-1:0] ADDR_RESULT = 4'h8;

	// STATUS word fields, each queue level gets a four bit slot
	localparam int ST_LVL_W = 4;
	localparam int ST_IQ_LSB = 0;
	localparam int ST_RQ_LSB = 4;
	localparam int ST_CNT_LSB = 8;
	localparam int CNT_W = 16;

endpackage

// ==== decode_rs2.sv ====
/*
  Second source register decoder for one 32-bit instruction.
  Gives the architectural register number of operand two with its bank,
  whether the instruction reads that operand and whether it is the
  hard-wired zero register. Purely combinational.
*/

`timescale 1ns/1ps

module decode_rs2 (
	input  logic [decode_pkg::INSN_W-1:0] insn,
	output logic [decode_pkg::AREG_W-1:0] rs2,
	output logic has_rs2,
	output logic rs2z
);

	logic [decode_pkg::OPC_W-1:0] opcode;
	logic [decode_pkg::RS2_W-1:0] rs2_field;
	logic [decode_pkg::CSR_SEL_W-1:0] csr_sel;
	logic immb;

	assign opcode = insn[decode_pkg::OPC_LSB +: decode_pkg::OPC_W];
	assign rs2_field = insn[decode_pkg::RS2_LSB +: decode_pkg::RS2_W];
	assign csr_sel = insn[decode_pkg::CSR_SEL_LSB +: decode_pkg::CSR_SEL_W];
	assign immb = insn[decode_pkg::IMMB_BIT];

	always_comb
	begin
		// Unknown opcodes and immediate operand B read no register
		rs2 = '0;
		has_rs2 = 1'b0;
		if (!immb)
		begin
			case (opcode)
			decode_pkg::OP_FLTH, decode_pkg::OP_FLTS,
			decode_pkg::OP_FLTD, decode_pkg::OP_FLTQ:
			begin
				rs2 = {decode_pkg::BANK_FLT, rs2_field};
				has_rs2 = 1'b1;
			end
			// Only the register form of a CSR access reads Rs2
			decode_pkg::OP_CSR:
			begin
				rs2 = {decode_pkg::BANK_INT, rs2_field};
				has_rs2 = (csr_sel == '0);
			end
			decode_pkg::OP_BCC8, decode_pkg::OP_BCC16,
			decode_pkg::OP_BCC32, decode_pkg::OP_BCC64,
			decode_pkg::OP_BCCU8, decode_pkg::OP_BCCU16,
			decode_pkg::OP_BCCU32, decode_pkg::OP_BCCU64,
			decode_pkg::OP_SHIFT,
			decode_pkg::OP_LDB, decode_pkg::OP_LDW, decode_pkg::OP_LOAD,
			decode_pkg::OP_STB, decode_pkg::OP_STW, decode_pkg::OP_STORE,
			decode_pkg::OP_AMO, decode_pkg::OP_CMPSWAP:
			begin
				rs2 = {decode_pkg::BANK_INT, rs2_field};
				has_rs2 = 1'b1;
			end
			// The field is still mapped for ALU immediates but not read
			decode_pkg::OP_ADDI, decode_pkg::OP_SUBFI, decode_pkg::OP_CMPI,
			decode_pkg::OP_ANDI, decode_pkg::OP_ORI, decode_pkg::OP_XORI,
			decode_pkg::OP_MULI:
			begin
				rs2 = {decode_pkg::BANK_INT, rs2_field};
				has_rs2 = 1'b0;
			end
			default:
			begin
				rs2 = '0;
				has_rs2 = 1'b0;
			end
			endcase
		end
	end

	// Integer register zero reads as the constant zero
	assign rs2z = has_rs2 & (rs2 == '0);

endmodule

// ==== decode_stage.sv ====
/*
  Decode consumer between the instruction queue and the result queue.
  Pops one instruction word, decodes operand two into a record held in a
  single output register and pushes that record into the result queue.
  Sustains one instruction per cycle and stalls while the result queue is
  full. Also counts the records it has pushed.
*/

`timescale 1ns/1ps

module decode_stage (
	input  logic clk,
	input  logic rst_n,
	input  logic insn_empty,
	input  logic [decode_pkg::INSN_W-1:0] insn_data,
	output logic insn_pop,
	input  logic res_full,
	output logic res_push,
	output logic [decode_pkg::RESULT_W-1:0] res_data,
	output logic [decode_pkg::CNT_W-1:0] decoded_count
);

	logic [decode_pkg::AREG_W-1:0] rs2;
	logic has_rs2;
	logic rs2z;
	logic [decode_pkg::RESULT_W-1:0] rec_next;
	logic [decode_pkg::RESULT_W-1:0] rec_q;
	logic out_valid;
	logic load;
	logic [decode_pkg::CNT_W-1:0] count;

	decode_rs2 u_rs2 (
		.insn(insn_data),
		.rs2(rs2),
		.has_rs2(has_rs2),
		.rs2z(rs2z)
	);

	// Pack the record fields in the layout the host reads back
	always_comb
	begin
		rec_next = '0;
		rec_next[decode_pkg::REC_RS2_LSB +: decode_pkg::AREG_W] = rs2;
		rec_next[decode_pkg::REC_HAS_BIT] = has_rs2;
		rec_next[decode_pkg::REC_Z_BIT] = rs2z;
		rec_next[decode_pkg::REC_OPC_LSB +: decode_pkg::OPC_W] =
			insn_data[decode_pkg::OPC_LSB +: decode_pkg::OPC_W];
	end

	// The record leaves whenever the result queue has room
	assign res_push = out_valid & ~res_full;

	// Register can take a new record if it is empty or draining this cycle
	assign load = ~out_valid | res_push;
	assign insn_pop = load & ~insn_empty;

	always_ff @(posedge clk)
	begin
		if (insn_pop)
			rec_q <= rec_next;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			count <= '0;
		end
		else
		begin
			if (load)
				out_valid <= ~insn_empty;
			// Count wraps after 65535 records
			if (res_push)
				count <= count + 1'b1;
		end
	end

	assign res_data = rec_q;
	assign decoded_count = count;

endmodule

// ==== insn_decode_top.sv ====
/*
  Top level of the instruction decode slice.
  Connects the APB slave to the instruction queue and the result queue and
  places the decode stage between the two queues. Both queues are the same
  FIFO with different payload types.
*/

`timescale 1ns/1ps

module insn_decode_top (
	input  logic clk,
	input  logic rst_n,
	input  logic [decode_pkg::APB_ADDR_W-1:0] paddr,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [decode_pkg::INSN_W-1:0] pwdata,
	output logic [decode_pkg::INSN_W-1:0] prdata,
	output logic pready,
	output logic pslverr
);

	// Instruction queue, written by the host and read by decode
	logic iq_push;
	logic [decode_pkg::INSN_W-1:0] iq_push_data;
	logic iq_full;
	logic iq_pop;
	logic [decode_pkg::INSN_W-1:0] iq_pop_data;
	logic iq_empty;
	logic [decode_pkg::INSN_LVL_W-1:0] iq_level;

	// Result queue, written by decode and read by the host
	logic rq_push;
	logic [decode_pkg::RESULT_W-1:0] rq_push_data;
	logic rq_full;
	logic rq_pop;
	logic [decode_pkg::RESULT_W-1:0] rq_pop_data;
	logic rq_empty;
	logic [decode_pkg::RES_LVL_W-1:0] rq_level;

	logic [decode_pkg::CNT_W-1:0] decoded_count;

	apb_insn_port u_apb (
		.clk(clk),
		.rst_n(rst_n),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.insn_push(iq_push),
		.insn_data(iq_push_data),
		.insn_full(iq_full),
		.insn_level(iq_level),
		.res_pop(rq_pop),
		.res_data(rq_pop_data),
		.res_empty(rq_empty),
		.res_level(rq_level),
		.decoded_count(decoded_count)
	);

	sync_fifo #(
		.payload_t(logic [decode_pkg::INSN_W-1:0]),
		.DEPTH(decode_pkg::INSN_DEPTH)
	) u_insn_q (
		.clk(clk),
		.rst_n(rst_n),
		.push(iq_push),
		.push_data(iq_push_data),
		.full(iq_full),
		.pop(iq_pop),
		.pop_data(iq_pop_data),
		.empty(iq_empty),
		.level(iq_level)
	);

	decode_stage u_dec (
		.clk(clk),
		.rst_n(rst_n),
		.insn_empty(iq_empty),
		.insn_data(iq_pop_data),
		.insn_pop(iq_pop),
		.res_full(rq_full),
		.res_push(rq_push),
		.res_data(rq_push_data),
		.decoded_count(decoded_count)
	);

	sync_fifo #(
		.payload_t(logic [decode_pkg::RESULT_W-1:0]),
		.DEPTH(decode_pkg::RESULT_DEPTH)
	) u_res_q (
		.clk(clk),
		.rst_n(rst_n),
		.push(rq_push),
		.push_data(rq_push_data),
		.full(rq_full),
		.pop(rq_pop),
		.pop_data(rq_pop_data),
		.empty(rq_empty),
		.level(rq_level)
	);

endmodule

// ==== list.f ====
decode_pkg.sv
sync_fifo.sv
apb_insn_port.sv
decode_rs2.sv
decode_stage.sv
insn_decode_top.sv
tb_insn_decode_assert.sv
tb_insn_decode.sv

// ==== run.sh ====
#!/bin/sh
# Build the decode slice testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_insn_decode -f list.f -o sim_tb \
	&& ./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1 \
	|| { echo "Build or simulation failed, see sim.log"; exit 1; }

grep -q -F '** PASS **' sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

// ==== sync_fifo.sv ====
/*
  Synchronous first-word-fall-through FIFO with a type parameter payload.
  The head entry shows on pop_data whenever empty is low and pop removes it
  at the next edge. Callers must not push while full or pop while empty.
  Serves as both the instruction queue and the decoded result queue.
*/

`timescale 1ns/1ps

module sync_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int DEPTH = 4
) (
	input  logic clk,
	input  logic rst_n,
	input  logic push,
	input  payload_t push_data,
	output logic full,
	input  logic pop,
	output payload_t pop_data,
	output logic empty,
	output logic [$clog2(DEPTH+1)-1:0] level
);

	// Pointer width stays at least one bit for a single entry queue
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push_ok;
	logic pop_ok;

	// Advance a pointer and wrap after the last entry, so DEPTH need not
	// be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(DEPTH - 1))
			return '0;
		else
			return p + 1'b1;
	endfunction

	// Illegal requests are dropped here so the counter never wraps
	assign push_ok = push & ~full;
	assign pop_ok = pop & ~empty;

	// Storage array, written at the tail only
	always_ff @(posedge clk)
	begin
		if (push_ok)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push_ok)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop_ok)
				rd_ptr <= next_ptr(rd_ptr);
			// Simultaneous push and pop leaves the occupancy unchanged
			if (push_ok && !pop_ok)
				count <= count + 1'b1;
			else if (pop_ok && !push_ok)
				count <= count - 1'b1;
		end
	end

	// Head of queue falls through without a read cycle
	assign pop_data = mem[rd_ptr];
	assign full = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);
	assign level = count;

endmodule

// ==== tb_insn_decode.sv ====
/*
  Directed testbench for the instruction decode slice.
  Writes instruction words over APB, polls STATUS until records appear and
  reads them back, comparing each against a reference model of the Rs2
  decode rules. Covers every opcode class, immediate operand B, CSR forms,
  back-pressure and error responses.
*/

`timescale 1ns/1ps

module tb_insn_decode;

	localparam int CLK_PERIOD = 8;
	localparam int SAMPLE_DLY = 2;
	localparam int READY_LIMIT = 16;
	localparam int POLL_LIMIT = 50;
	localparam int OP_COUNT = 29;
	localparam logic [3:0] ADDR_UNMAPPED = 4'hC;

	// Every defined opcode, in class order
	localparam logic [6:0] ALL_OPS [OP_COUNT] = '{
		decode_pkg::OP_FLTH, decode_pkg::OP_FLTS, decode_pkg::OP_FLTD, decode_pkg::OP_FLTQ,
		decode_pkg::OP_CSR,
		decode_pkg::OP_BCC8, decode_pkg::OP_BCC16, decode_pkg::OP_BCC32, decode_pkg::OP_BCC64,
		decode_pkg::OP_BCCU8, decode_pkg::OP_BCCU16, decode_pkg::OP_BCCU32,
		decode_pkg::OP_BCCU64,
		decode_pkg::OP_ADDI, decode_pkg::OP_SUBFI, decode_pkg::OP_CMPI, decode_pkg::OP_ANDI,
		decode_pkg::OP_ORI, decode_pkg::OP_XORI, decode_pkg::OP_MULI,
		decode_pkg::OP_SHIFT,
		decode_pkg::OP_LDB, decode_pkg::OP_LDW, decode_pkg::OP_LOAD,
		decode_pkg::OP_STB, decode_pkg::OP_STW, decode_pkg::OP_STORE,
		decode_pkg::OP_AMO, decode_pkg::OP_CMPSWAP
	};

	logic clk;
	logic rst_n;
	logic [3:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	integer seed;
	int errors;
	int checks;
	int accepted;

	insn_decode_top dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ========================================================================
	// Checking and reference model
	// ========================================================================

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
			errors++;
		end
	endtask

	// Record layout is rs2 in 7:0, has_rs2 in 8, rs2z in 9, opcode in 16:10
	function automatic logic [31:0] model_record(input logic [31:0] insn);
		logic [6:0] opc;
		logic [5:0] field;
		logic [7:0] rs2;
		logic has;
		opc = insn[6:0];
		field = insn[24:19];
		rs2 = 8'h00;
		has = 1'b0;
		// Immediate operand B means no register at all
		if (!insn[25])
		begin
			if (opc inside {decode_pkg::OP_FLTH, decode_pkg::OP_FLTS, decode_pkg::OP_FLTD,
				decode_pkg::OP_FLTQ})
			begin
				rs2 = {2'b01, field};
				has = 1'b1;
			end
			else if (opc == decode_pkg::OP_CSR)
			begin
				rs2 = {2'b00, field};
				has = (insn[31:29] == 3'b000);
			end
			else if (opc inside {decode_pkg::OP_BCC8, decode_pkg::OP_BCC16,
				decode_pkg::OP_BCC32, decode_pkg::OP_BCC64, decode_pkg::OP_BCCU8,
				decode_pkg::OP_BCCU16, decode_pkg::OP_BCCU32, decode_pkg::OP_BCCU64,
				decode_pkg::OP_SHIFT, decode_pkg::OP_LDB, decode_pkg::OP_LDW,
				decode_pkg::OP_LOAD, decode_pkg::OP_STB, decode_pkg::OP_STW,
				decode_pkg::OP_STORE, decode_pkg::OP_AMO, decode_pkg::OP_CMPSWAP})
			begin
				rs2 = {2'b00, field};
				has = 1'b1;
			end
			// ALU immediates still map the field, it is just never read
			else if (opc inside {decode_pkg::OP_ADDI, decode_pkg::OP_SUBFI,
				decode_pkg::OP_CMPI, decode_pkg::OP_ANDI, decode_pkg::OP_ORI,
				decode_pkg::OP_XORI, decode_pkg::OP_MULI})
				rs2 = {2'b00, field};
		end
		return {15'h0000, opc, has && (rs2 == 8'h00), has, rs2};
	endfunction

	task automatic check_record(input logic [31:0] got, input logic [31:0] exp);
		check_eq("record.rs2", 32'(got[7:0]), 32'(exp[7:0]));
		check_eq("record.has_rs2", 32'(got[8]), 32'(exp[8]));
		check_eq("record.rs2z", 32'(got[9]), 32'(exp[9]));
		check_eq("record.opcode", 32'(got[16:10]), 32'(exp[16:10]));
		check_eq("prdata[31:17]", 32'(got[31:17]), 32'(exp[31:17]));
	endtask

	// ========================================================================
	// APB transfers
	// ========================================================================

	// Setup and access are driven on falling edges, results sampled mid low
	task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		int waits;
		waits = 0;
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		#SAMPLE_DLY;
		while (!pready && waits < READY_LIMIT)
		begin
			@(negedge clk);
			#SAMPLE_DLY;
			waits++;
		end
		if (!pready)
		begin
			$display("APB transfer to 0x%0h never saw pready at %0t", addr, $time);
			errors++;
		end
		rdata = prdata;
		err = pslverr;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused_rd;
		apb_xfer(1'b1, addr, data, unused_rd, err);
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
		apb_xfer(1'b0, addr, 32'h0, data, err);
	endtask

	// Poll STATUS until the result queue holds enough records
	task automatic wait_result_level(input int min_level);
		logic [31:0] status;
		logic err;
		int polls;
		polls = 0;
		apb_read(decode_pkg::ADDR_STATUS, status, err);
		while (int'(status[7:4]) < min_level && polls < POLL_LIMIT)
		begin
			apb_read(decode_pkg::ADDR_STATUS, status, err);
			polls++;
		end
		if (int'(status[7:4]) < min_level)
		begin
			$display("Timeout at %0t: result queue level stayed below %0d", $time, min_level);
			errors++;
		end
	endtask

	// ========================================================================
	// Stimulus helpers and tests
	// ========================================================================

	// Fields the test does not care about come from the seeded generator
	task automatic make_insn(input logic [6:0] opc, input logic immb, output logic [31:0] insn);
		insn = $random(seed);
		insn[6:0] = opc;
		insn[25] = immb;
	endtask

	task automatic send_and_fetch(input logic [31:0] insn, output logic [31:0] rec);
		logic err;
		apb_write(decode_pkg::ADDR_INSN, insn, err);
		check_eq("pslverr on INSN write", 32'(err), 32'd0);
		if (!err)
			accepted++;
		wait_result_level(1);
		apb_read(decode_pkg::ADDR_RESULT, rec, err);
		check_eq("pslverr on RESULT read", 32'(err), 32'd0);
	endtask

	task automatic test_opcode_classes();
		logic [31:0] insn;
		logic [31:0] rec;
		for (int i = 0; i < OP_COUNT; i++)
		begin
			make_insn(ALL_OPS[i], 1'b0, insn);
			send_and_fetch(insn, rec);
			check_record(rec, model_record(insn));
		end
	endtask

	task automatic test_no_rs2();
		logic [31:0] insn;
		logic [31:0] rec;
		logic [6:0] unknown [3];
		unknown = '{7'h00, 7'h11, 7'h7F};
		for (int i = 0; i < OP_COUNT; i++)
		begin
			make_insn(ALL_OPS[i], 1'b1, insn);
			send_and_fetch(insn, rec);
			check_record(rec, {15'h0000, ALL_OPS[i], 10'h000});
		end
		for (int i = 0; i < 3; i++)
		begin
			make_insn(unknown[i], 1'b0, insn);
			send_and_fetch(insn, rec);
			check_record(rec, {15'h0000, unknown[i], 10'h000});
		end
	endtask

	task automatic test_csr_and_zero();
		logic [31:0] insn;
		logic [31:0] rec;
		logic [2:0] sels [2];
		logic [5:0] fields [2];
		sels = '{3'b000, 3'b101};
		fields = '{6'd0, 6'd37};
		// Register and immediate CSR forms, each with a zero and a nonzero field
		for (int s = 0; s < 2; s++)
			for (int f = 0; f < 2; f++)
			begin
				make_insn(decode_pkg::OP_CSR, 1'b0, insn);
				insn[31:29] = sels[s];
				insn[24:19] = fields[f];
				send_and_fetch(insn, rec);
				check_record(rec, model_record(insn));
			end
		make_insn(decode_pkg::OP_BCC32, 1'b0, insn);
		insn[24:19] = 6'd0;
		send_and_fetch(insn, rec);
		check_record(rec, model_record(insn));
		check_eq("rs2z on branch with Rs2 field zero", 32'(rec[9]), 32'd1);
	endtask

	task automatic test_back_pressure();
		logic [31:0] sent [$];
		logic [31:0] insn;
		logic [31:0] rec;
		logic err;
		int idx;
		// Nine words fill the instruction queue, output register and result queue
		for (int i = 0; i < 9; i++)
		begin
			idx = $unsigned($random(seed)) % OP_COUNT;
			make_insn(ALL_OPS[idx], 1'b0, insn);
			apb_write(decode_pkg::ADDR_INSN, insn, err);
			check_eq("pslverr on write below capacity", 32'(err), 32'd0);
			if (!err)
			begin
				accepted++;
				sent.push_back(insn);
			end
		end
		make_insn(decode_pkg::OP_LOAD, 1'b0, insn);
		apb_write(decode_pkg::ADDR_INSN, insn, err);
		check_eq("pslverr on write while full", 32'(err), 32'd1);
		apb_read(decode_pkg::ADDR_STATUS, rec, err);
		check_eq("status.iq_level when full", 32'(rec[3:0]), 32'd4);
		check_eq("status.rq_level when full", 32'(rec[7:4]), 32'd4);
		while (sent.size() > 0)
		begin
			insn = sent.pop_front();
			wait_result_level(1);
			apb_read(decode_pkg::ADDR_RESULT, rec, err);
			check_eq("pslverr on RESULT read", 32'(err), 32'd0);
			check_record(rec, model_record(insn));
		end
	endtask

	task automatic test_status_errors();
		logic [31:0] data;
		logic err;
		apb_read(decode_pkg::ADDR_RESULT, data, err);
		check_eq("pslverr on empty RESULT read", 32'(err), 32'd1);
		check_eq("prdata on empty RESULT read", data, 32'd0);
		apb_read(ADDR_UNMAPPED, data, err);
		check_eq("pslverr on unmapped read", 32'(err), 32'd1);
		apb_write(ADDR_UNMAPPED, 32'h1234_5678, err);
		check_eq("pslverr on unmapped write", 32'(err), 32'd1);
		apb_read(decode_pkg::ADDR_STATUS, data, err);
		check_eq("pslverr on STATUS read", 32'(err), 32'd0);
		check_eq("status.iq_level after drain", 32'(data[3:0]), 32'd0);
		check_eq("status.rq_level after drain", 32'(data[7:4]), 32'd0);
		check_eq("status.decoded_count", 32'(data[23:8]), 32'(accepted));
	endtask

	initial
	begin
		logic [31:0] status;
		logic err;
		seed = 32'h20ab_f5a3;
		errors = 0;
		checks = 0;
		accepted = 0;
		clk = 1'b0;
		rst_n = 1'b0;
		paddr = 4'h0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = 32'h0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// Queues empty and count zero out of reset
		apb_read(decode_pkg::ADDR_STATUS, status, err);
		check_eq("STATUS after reset", status, 32'd0);
		test_opcode_classes();
		test_no_rs2();
		test_csr_and_zero();
		test_back_pressure();
		test_status_errors();
		errors += dut0.u_checks.fail_count;
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== tb_insn_decode_assert.sv ====
/*
  Concurrent protocol and queue checks for the decode slice.
  Bound into the top level so it sees the APB pins and both queues.
  Each failure bumps a counter that the testbench folds into its totals.
*/

`timescale 1ns/1ps

module tb_insn_decode_assert (
	input  logic clk,
	input  logic rst_n,
	input  logic psel,
	input  logic penable,
	input  logic pready,
	input  logic [decode_pkg::INSN_LVL_W-1:0] iq_level,
	input  logic [decode_pkg::RES_LVL_W-1:0] rq_level,
	input  logic iq_push,
	input  logic iq_full,
	input  logic rq_push,
	input  logic rq_full
);

	int fail_count = 0;

	// No wait states, so every access cycle completes at once
	a_pready: assert property (@(posedge clk) disable iff (!rst_n)
		(psel && penable) |-> pready)
	else
	begin
		$error("pready low during an APB access cycle");
		fail_count++;
	end

	// Occupancy stays within the configured depths
	a_iq_level: assert property (@(posedge clk) disable iff (!rst_n)
		32'(iq_level) <= decode_pkg::INSN_DEPTH)
	else
	begin
		$error("instruction queue level above its depth");
		fail_count++;
	end

	a_rq_level: assert property (@(posedge clk) disable iff (!rst_n)
		32'(rq_level) <= decode_pkg::RESULT_DEPTH)
	else
	begin
		$error("result queue level above its depth");
		fail_count++;
	end

	a_iq_push: assert property (@(posedge clk) disable iff (!rst_n) !(iq_push && iq_full))
	else
	begin
		$error("push into a full instruction queue");
		fail_count++;
	end

	a_rq_push: assert property (@(posedge clk) disable iff (!rst_n) !(rq_push && rq_full))
	else
	begin
		$error("push into a full result queue");
		fail_count++;
	end

endmodule

bind insn_decode_top tb_insn_decode_assert u_checks (
	.clk(clk),
	.rst_n(rst_n),
	.psel(psel),
	.penable(penable),
	.pready(pready),
	.iq_level(iq_level),
	.rq_level(rq_level),
	.iq_push(iq_push),
	.iq_full(iq_full),
	.rq_push(rq_push),
	.rq_full(rq_full)
);
